/* lspStability_defs.svh */
`ifndef LSP_STABILITY_DEFS_SVH
`define LSP_STABILITY_DEFS_SVH

//////////////////////////////////////////////////
// Scratch memory geometry
//////////////////////////////////////////////////
`define LSP_ADDR_W 11
`define LSP_DATA_W 32
`define LSP_DEPTH 2048

// LSF values per block
`define LSP_ORDER 10

//////////////////////////////////////////////////
// Stability limits in Q13
//////////////////////////////////////////////////
// Floor for the first LSF
`define LSP_L_LIMIT 40
// Ceiling for the last LSF
`define LSP_M_LIMIT 25681
// Minimum spacing of neighbours
`define LSP_GAP3 321

`endif

/* lspPkg.sv */
package lspPkg;

	// Codec words, always signed
	typedef logic signed [15:0] word16T;
	typedef logic signed [31:0] word32T;

	// Controller states
	typedef enum logic [3:0] {
		stIdle,
		stSortRead,
		stSortCmp,
		stSortWrite,
		stLowClamp,
		stGapRead,
		stGapCmp,
		stGapWrite,
		stHighClamp,
		stFinish
	} stabStateT;

endpackage

/* basicOps.sv */
module basicOps import lspPkg::*; (
	input  word16T addOutA,
	input  word16T addOutB,
	input  word16T subOutA,
	input  word16T subOutB,
	input  word32T lAddOutA,
	input  word32T lAddOutB,
	input  word32T lSubOutA,
	input  word32T lSubOutB,
	output word16T addIn,
	output word16T subIn,
	output word32T lAddIn,
	output word32T lSubIn
);

	// Saturation bounds
	localparam word16T maxWord16 = 16'sh7fff;
	localparam word16T minWord16 = 16'sh8000;
	localparam word32T maxWord32 = 32'sh7fff_ffff;
	localparam word32T minWord32 = 32'sh8000_0000;

	logic signed [16:0] addWide;
	logic signed [16:0] subWide;
	word32T lAddRaw;
	word32T lSubRaw;
	logic addOvf;
	logic subOvf;
	logic lAddOvf;
	logic lSubOvf;

	//////////////////////////////////////////////////
	// 16-bit add and sub
	//////////////////////////////////////////////////
	always_comb
	begin
		// One guard bit shows overflow
		addWide = {addOutA[15], addOutA} + {addOutB[15], addOutB};
		subWide = {subOutA[15], subOutA} - {subOutB[15], subOutB};
		addOvf = addWide[16] ^ addWide[15];
		subOvf = subWide[16] ^ subWide[15];
		// Guard bit gives the true sign
		addIn = addOvf ? (addWide[16] ? minWord16 : maxWord16) : addWide[15:0];
		subIn = subOvf ? (subWide[16] ? minWord16 : maxWord16) : subWide[15:0];
	end

	//////////////////////////////////////////////////
	// 32-bit add and sub
	//////////////////////////////////////////////////
	always_comb
	begin
		lAddRaw = lAddOutA + lAddOutB;
		lSubRaw = lSubOutA - lSubOutB;
		// Like signs in, other sign out
		lAddOvf = (lAddOutA[31] == lAddOutB[31]) && (lAddRaw[31] != lAddOutA[31]);
		// Unlike signs in, result flips away from A
		lSubOvf = (lSubOutA[31] != lSubOutB[31]) && (lSubRaw[31] != lSubOutA[31]);
		// Clip toward the sign of A
		lAddIn = lAddOvf ? (lAddOutA[31] ? minWord32 : maxWord32) : lAddRaw;
		lSubIn = lSubOvf ? (lSubOutA[31] ? minWord32 : maxWord32) : lSubRaw;
	end

endmodule

/* scratchMemory.sv */
`include "lspStability_defs.svh"

module scratchMemory (
	input  logic clk,
	input  logic [`LSP_ADDR_W-1:0] writeAddr,
	input  logic [`LSP_DATA_W-1:0] writeData,
	input  logic writeEn,
	input  logic [`LSP_ADDR_W-1:0] readAddr,
	output logic [`LSP_DATA_W-1:0] readData
);

	// Word storage
	logic [`LSP_DATA_W-1:0] mem [0:`LSP_DEPTH-1];

	//////////////////////////////////////////////////
	// Write port and registered read port
	//////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (writeEn)
		begin
			mem[writeAddr] <= writeData;
		end
		// Same-address read in a write cycle sees the old word
		readData <= mem[readAddr];
	end

	// A write needs a known address inside the array
	writeAddrKnown: assert property (
		@(posedge clk) writeEn |-> !$isunknown(writeAddr)
	);

endmodule

/* lspStabilityFsm.sv */
`include "lspStability_defs.svh"

module lspStabilityFsm import lspPkg::*; (
	input  logic clk,
	input  logic rstN,
	input  logic start,
	input  logic [`LSP_ADDR_W-1:0] bufAddr,
	input  word16T addIn,
	input  word16T subIn,
	input  word32T lAddIn,
	input  word32T lSubIn,
	input  logic [`LSP_DATA_W-1:0] memIn,
	output word16T addOutA,
	output word16T addOutB,
	output word16T subOutA,
	output word16T subOutB,
	output word32T lAddOutA,
	output word32T lAddOutB,
	output word32T lSubOutA,
	output word32T lSubOutB,
	output logic [`LSP_ADDR_W-1:0] memReadAddr,
	output logic [`LSP_ADDR_W-1:0] memWriteAddr,
	output logic [`LSP_DATA_W-1:0] memOut,
	output logic memWriteEn,
	output logic done
);

	stabStateT state;
	stabStateT stateNext;
	// i walks the pair, j counts sort passes
	logic [3:0] i;
	logic [3:0] iNext;
	logic [3:0] j;
	logic [3:0] jNext;
	// Second cycle of a read or write pair
	logic phase;
	logic phaseNext;
	// Holding registers for neighbouring values
	word16T regA;
	word16T regB;
	word16T memWord;
	word16T writeWord;
	logic addOne;
	logic [3:0] offset;
	logic below;
	logic passEnd;
	// Write address relative to the block
	logic [`LSP_ADDR_W-1:0] writeOffset;

	// Low half of the memory word is the LSF
	assign memWord = memIn[15:0];
	// Sign of the shared 32-bit difference
	assign below = lSubIn[31];
	// Last pair of this sort pass
	assign passEnd = ({12'd0, i} == subIn);

	//////////////////////////////////////////////////
	// Operand routing to the shared operators
	//////////////////////////////////////////////////
	always_comb
	begin
		case (state)
			stSortRead, stSortWrite, stGapRead: addOne = phase;
			stGapWrite, stHighClamp: addOne = 1'b1;
			default: addOne = 1'b0;
		endcase
		offset = i + {3'd0, addOne};
		// Buffer address is bufAddr plus the index
		lAddOutA = {{(32 - `LSP_ADDR_W){1'b0}}, bufAddr};
		lAddOutB = {28'd0, offset};
		// Next value for the gap pass
		addOutA = regA;
		addOutB = word16T'(`LSP_GAP3);
		// Last index of pass j
		subOutA = word16T'(`LSP_ORDER - 2);
		subOutB = {12'd0, j};
		case (state)
			stLowClamp:
			begin
				lSubOutA = word32T'(regA);
				lSubOutB = word32T'(`LSP_L_LIMIT);
			end
			stGapCmp:
			begin
				lSubOutA = word32T'(memWord);
				lSubOutB = word32T'(addIn);
			end
			stHighClamp:
			begin
				lSubOutA = word32T'(`LSP_M_LIMIT);
				lSubOutB = word32T'(regB);
			end
			// Sort compare of buf[i+1] against buf[i]
			default:
			begin
				lSubOutA = word32T'(memWord);
				lSubOutB = word32T'(regA);
			end
		endcase
	end

	// Reads and writes never share a cycle
	assign memReadAddr = lAddIn[`LSP_ADDR_W-1:0];
	assign memWriteAddr = lAddIn[`LSP_ADDR_W-1:0];
	assign writeOffset = memWriteAddr - bufAddr;

	//////////////////////////////////////////////////
	// Write-back data
	//////////////////////////////////////////////////
	always_comb
	begin
		case (state)
			// Smaller value first
			stSortWrite: writeWord = phase ? regB : regA;
			stLowClamp: writeWord = below ? word16T'(`LSP_L_LIMIT) : regA;
			stHighClamp: writeWord = below ? word16T'(`LSP_M_LIMIT) : regB;
			default: writeWord = regB;
		endcase
		memOut = {{(`LSP_DATA_W - 16){writeWord[15]}}, writeWord};
	end

	assign memWriteEn = state inside {stSortWrite, stLowClamp, stGapWrite, stHighClamp};
	assign done = (state == stFinish);

	//////////////////////////////////////////////////
	// Next state and counters
	//////////////////////////////////////////////////
	always_comb
	begin
		stateNext = state;
		iNext = i;
		jNext = j;
		phaseNext = 1'b0;
		case (state)
			stIdle:
			begin
				if (start)
				begin
					stateNext = stSortRead;
					iNext = '0;
					jNext = '0;
				end
			end
			stSortRead:
			begin
				phaseNext = !phase;
				if (phase)
				begin
					stateNext = stSortCmp;
				end
			end
			stSortCmp, stSortWrite:
			begin
				if (state == stSortCmp && below)
				begin
					stateNext = stSortWrite;
				end
				else if (state == stSortWrite && !phase)
				begin
					phaseNext = 1'b1;
				end
				else if (!passEnd)
				begin
					stateNext = stSortRead;
					iNext = i + 4'd1;
				end
				else if (j == 4'(`LSP_ORDER - 2))
				begin
					stateNext = stLowClamp;
					iNext = '0;
				end
				else
				begin
					// Next pass is one pair shorter
					stateNext = stSortRead;
					iNext = '0;
					jNext = j + 4'd1;
				end
			end
			stLowClamp: stateNext = stGapRead;
			stGapRead:
			begin
				phaseNext = !phase;
				if (phase)
				begin
					stateNext = stGapCmp;
				end
			end
			stGapCmp, stGapWrite:
			begin
				if (state == stGapCmp && below)
				begin
					stateNext = stGapWrite;
				end
				else if (i == 4'(`LSP_ORDER - 2))
				begin
					stateNext = stHighClamp;
				end
				else
				begin
					stateNext = stGapRead;
					iNext = i + 4'd1;
				end
			end
			stHighClamp: stateNext = stFinish;
			default: stateNext = stIdle;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			state <= stIdle;
			i <= '0;
			j <= '0;
			phase <= 1'b0;
		end
		else
		begin
			state <= stateNext;
			i <= iNext;
			j <= jNext;
			phase <= phaseNext;
		end
	end

	//////////////////////////////////////////////////
	// Holding registers
	//////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		case (state)
			// buf[i] arrives on the second read cycle
			stSortRead, stGapRead:
			begin
				if (phase)
				begin
					regA <= memWord;
				end
			end
			// Keep the pair in ascending order
			stSortCmp:
			begin
				if (below)
				begin
					regA <= memWord;
					regB <= regA;
				end
				else
				begin
					regB <= memWord;
				end
			end
			stGapCmp: regB <= below ? addIn : memWord;
		endcase
	end

	// done lasts one cycle before idle
	doneOnePulse: assert property (
		@(posedge clk) disable iff (!rstN) done |=> !done
	);
	// Controller writes stay inside the ten-word block
	writeInBlock: assert property (
		@(posedge clk) disable iff (!rstN) memWriteEn |-> (writeOffset < `LSP_ORDER)
	);
	indexInRange: assert property (
		@(posedge clk) disable iff (!rstN) i < `LSP_ORDER
	);

endmodule

/* lspStabilityPipe.sv */
`include "lspStability_defs.svh"

module lspStabilityPipe import lspPkg::*; (
	input  logic clk,
	input  logic rstN,
	input  logic start,
	input  logic stabilityMuxSel,
	input  logic [`LSP_ADDR_W-1:0] testReadAddr,
	input  logic [`LSP_ADDR_W-1:0] testWriteAddr,
	input  logic [`LSP_DATA_W-1:0] testMemOut,
	input  logic testMemWriteEn,
	input  logic [`LSP_ADDR_W-1:0] bufAddr,
	output logic [`LSP_DATA_W-1:0] memIn,
	output logic done
);

	// Selected memory port signals
	logic [`LSP_ADDR_W-1:0] readAddrSel;
	logic [`LSP_ADDR_W-1:0] writeAddrSel;
	logic [`LSP_DATA_W-1:0] writeDataSel;
	logic writeEnSel;
	// Controller side of the memory
	logic [`LSP_ADDR_W-1:0] memReadAddr;
	logic [`LSP_ADDR_W-1:0] memWriteAddr;
	logic [`LSP_DATA_W-1:0] memOut;
	logic memWriteEn;
	// Operator operands and results
	word16T addOutA;
	word16T addOutB;
	word16T subOutA;
	word16T subOutB;
	word32T lAddOutA;
	word32T lAddOutB;
	word32T lSubOutA;
	word32T lSubOutB;
	word16T addIn;
	word16T subIn;
	word32T lAddIn;
	word32T lSubIn;

	//////////////////////////////////////////////////
	// Memory access select
	//////////////////////////////////////////////////
	always_comb
	begin
		if (stabilityMuxSel)
		begin
			// Test port owns the memory
			readAddrSel = testReadAddr;
			writeAddrSel = testWriteAddr;
			writeDataSel = testMemOut;
			writeEnSel = testMemWriteEn;
		end
		else
		begin
			readAddrSel = memReadAddr;
			writeAddrSel = memWriteAddr;
			writeDataSel = memOut;
			writeEnSel = memWriteEn;
		end
	end

	scratchMemory i_scratchMemory (
		.clk(clk),
		.writeAddr(writeAddrSel),
		.writeData(writeDataSel),
		.writeEn(writeEnSel),
		.readAddr(readAddrSel),
		.readData(memIn)
	);

	basicOps i_basicOps (
		.addOutA(addOutA),
		.addOutB(addOutB),
		.subOutA(subOutA),
		.subOutB(subOutB),
		.lAddOutA(lAddOutA),
		.lAddOutB(lAddOutB),
		.lSubOutA(lSubOutA),
		.lSubOutB(lSubOutB),
		.addIn(addIn),
		.subIn(subIn),
		.lAddIn(lAddIn),
		.lSubIn(lSubIn)
	);

	// memIn also feeds the controller
	lspStabilityFsm i_lspStabilityFsm (
		.clk(clk),
		.rstN(rstN),
		.start(start),
		.bufAddr(bufAddr),
		.addIn(addIn),
		.subIn(subIn),
		.lAddIn(lAddIn),
		.lSubIn(lSubIn),
		.memIn(memIn),
		.addOutA(addOutA),
		.addOutB(addOutB),
		.subOutA(subOutA),
		.subOutB(subOutB),
		.lAddOutA(lAddOutA),
		.lAddOutB(lAddOutB),
		.lSubOutA(lSubOutA),
		.lSubOutB(lSubOutB),
		.memReadAddr(memReadAddr),
		.memWriteAddr(memWriteAddr),
		.memOut(memOut),
		.memWriteEn(memWriteEn),
		.done(done)
	);

endmodule

/* tb_lspStability.sv */
`include "lspStability_defs.svh"

module tb_lspStability;
	timeunit 1ns;
	timeprecision 1ps;

	// Run length of all cases together
	localparam int caseLimit = 20;
	localparam int cyclesPerCase = 600;
	localparam int cycleLimit = caseLimit * cyclesPerCase + 1000;
	// Galois taps 32, 22, 2, 1
	localparam logic [31:0] lfsrMask = 32'h8020_0003;

	logic clk;
	logic rstN;
	logic start;
	logic stabilityMuxSel;
	logic [`LSP_ADDR_W-1:0] testReadAddr;
	logic [`LSP_ADDR_W-1:0] testWriteAddr;
	logic [`LSP_DATA_W-1:0] testMemOut;
	logic testMemWriteEn;
	logic [`LSP_ADDR_W-1:0] bufAddr;
	logic [`LSP_DATA_W-1:0] memIn;
	logic done;

	logic [31:0] lfsrState = 32'h0bdb030a;
	int inVals [0:`LSP_ORDER-1];
	int expVals [0:`LSP_ORDER-1];
	// Readbacks in flight with the oldest first
	logic [31:0] expQ [$];
	string nameQ [$];
	logic readValid;
	logic readValidQ;
	int errorCount = 0;
	int checkCount = 0;
	int caseCount = 0;
	int cycleCount = 0;

	lspStabilityPipe i_lspStabilityPipe (
		.clk(clk),
		.rstN(rstN),
		.start(start),
		.stabilityMuxSel(stabilityMuxSel),
		.testReadAddr(testReadAddr),
		.testWriteAddr(testWriteAddr),
		.testMemOut(testMemOut),
		.testMemWriteEn(testMemWriteEn),
		.bufAddr(bufAddr),
		.memIn(memIn),
		.done(done)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Helpers and reference model
	//////////////////////////////////////////////////
	// One LFSR step per bit taken
	function automatic logic [31:0] randomBits(int count);
		logic [31:0] bits;
		int k;
		bits = '0;
		for (k = 0; k < count; k++)
		begin
			bits = {bits[30:0], lfsrState[0]};
			lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ lfsrMask) : (lfsrState >> 1);
		end
		return bits;
	endfunction

	// Fill word built from every address bit
	function automatic logic [31:0] addrPattern(logic [`LSP_ADDR_W-1:0] addr);
		return {5'h15, addr, ~addr, 5'h0a};
	endfunction

	function automatic int saturate16(int value);
		if (value > 32767)
		begin
			return 32767;
		end
		if (value < -32768)
		begin
			return -32768;
		end
		return value;
	endfunction

	// Sort, low clamp, gap pass, high clamp
	function automatic void stabilizeReference();
		int k;
		int m;
		int tmp;
		int nextMin;
		for (k = 0; k < `LSP_ORDER; k++)
		begin
			expVals[k] = inVals[k];
		end
		// Insertion sort, ascending
		for (k = 1; k < `LSP_ORDER; k++)
		begin
			tmp = expVals[k];
			m = k - 1;
			while (m >= 0 && expVals[m] > tmp)
			begin
				expVals[m + 1] = expVals[m];
				m--;
			end
			expVals[m + 1] = tmp;
		end
		if (expVals[0] < `LSP_L_LIMIT)
		begin
			expVals[0] = `LSP_L_LIMIT;
		end
		for (k = 0; k < `LSP_ORDER - 1; k++)
		begin
			nextMin = saturate16(expVals[k] + `LSP_GAP3);
			if (expVals[k + 1] < nextMin)
			begin
				expVals[k + 1] = nextMin;
			end
		end
		if (expVals[`LSP_ORDER - 1] > `LSP_M_LIMIT)
		begin
			expVals[`LSP_ORDER - 1] = `LSP_M_LIMIT;
		end
	endfunction

	task automatic checkValue(string name, logic [31:0] expected, logic [31:0] actual);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("[ERROR] %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
		end
	endtask

	// Inputs move 2 ns past the edge
	task automatic stepCycle();
		@(posedge clk);
		#2;
	endtask

	task automatic writeWord(logic [`LSP_ADDR_W-1:0] addr, logic [31:0] data);
		testWriteAddr = addr;
		testMemOut = data;
		testMemWriteEn = 1'b1;
		stepCycle();
		testMemWriteEn = 1'b0;
	endtask

	task automatic requestRead(logic [`LSP_ADDR_W-1:0] addr, logic [31:0] expected);
		testReadAddr = addr;
		readValid = 1'b1;
		expQ.push_back(expected);
		nameQ.push_back($sformatf("memIn[0x%03h]", addr));
		stepCycle();
		readValid = 1'b0;
	endtask

	task automatic waitDone();
		@(negedge clk);
		while (done !== 1'b1)
		begin
			@(negedge clk);
		end
		stepCycle();
		// done is a single-cycle pulse
		checkValue("done", 32'h0, {31'd0, done});
	endtask

	// Load, run the controller, read back with guard words
	task automatic runCase(logic [`LSP_ADDR_W-1:0] base);
		int k;
		stabilityMuxSel = 1'b1;
		bufAddr = base;
		writeWord(base - 1, addrPattern(base - 1));
		for (k = 0; k < `LSP_ORDER; k++)
		begin
			writeWord(base + k, inVals[k]);
		end
		writeWord(base + `LSP_ORDER, addrPattern(base + `LSP_ORDER));
		stabilityMuxSel = 1'b0;
		start = 1'b1;
		stepCycle();
		start = 1'b0;
		waitDone();
		stabilityMuxSel = 1'b1;
		stabilizeReference();
		requestRead(base - 1, addrPattern(base - 1));
		for (k = 0; k < `LSP_ORDER; k++)
		begin
			requestRead(base + k, expVals[k]);
		end
		requestRead(base + `LSP_ORDER, addrPattern(base + `LSP_ORDER));
		stepCycle();
		caseCount++;
	endtask

	//////////////////////////////////////////////////
	// Readback compare one cycle behind the address
	//////////////////////////////////////////////////
	always @(posedge clk)
	begin
		readValidQ <= readValid;
	end

	always @(negedge clk)
	begin
		if (readValidQ)
		begin
			checkValue(nameQ.pop_front(), expQ.pop_front(), memIn);
		end
	end

	// Cycle limit for the whole run
	initial
	begin
		while (cycleCount < cycleLimit)
		begin
			@(posedge clk);
			cycleCount++;
		end
		$display("Timeout: done never arrived within %0d cycles", cycleLimit);
		$display("Cases: %0d, checks: %0d, errors: %0d", caseCount, checkCount, errorCount);
		$display("TESTS FAILED");
		$finish;
	end

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////
	initial
	begin
		logic [`LSP_ADDR_W-1:0] addrList [0:15];
		int k;
		int n;
		rstN = 1'b0;
		start = 1'b0;
		stabilityMuxSel = 1'b1;
		testReadAddr = '0;
		testWriteAddr = '0;
		testMemOut = '0;
		testMemWriteEn = 1'b0;
		bufAddr = '0;
		readValid = 1'b0;
		repeat (10) @(posedge clk);
		#2;
		rstN = 1'b1;
		stepCycle();

		// Test port alone with both ends of the array included
		addrList[0] = '0;
		addrList[1] = '1;
		for (k = 2; k < 16; k++)
		begin
			addrList[k] = randomBits(`LSP_ADDR_W);
		end
		for (k = 0; k < 16; k++)
		begin
			writeWord(addrList[k], addrPattern(addrList[k]));
		end
		for (k = 0; k < 16; k++)
		begin
			requestRead(addrList[k], addrPattern(addrList[k]));
		end
		stepCycle();

		// Random values at random placement
		for (n = 0; n < 12; n++)
		begin
			for (k = 0; k < `LSP_ORDER; k++)
			begin
				inVals[k] = int'(randomBits(15));
			end
			runCase(randomBits(10) + 1);
		end

		// Smallest value under the low limit
		inVals = '{1200, 300, 9000, 5, 4000, 20000, 2500, 15000, 6000, 12000};
		runCase(1);
		// Crowded near the top with saturating gaps
		inVals = '{32700, 32750, 32767, 32600, 32500, 32760, 32740, 32720, 32710, 32730};
		runCase(`LSP_DEPTH - `LSP_ORDER - 1);
		// Already sorted and spaced
		inVals = '{1000, 3000, 5000, 7000, 9000, 11000, 13000, 15000, 17000, 19000};
		runCase(700);
		// Reverse order swaps on every compare
		inVals = '{19000, 17000, 15000, 13000, 11000, 9000, 7000, 5000, 3000, 1000};
		runCase(1300);
		// Full signed range
		inVals = '{-32768, -100, 0, 32767, -5000, 500, 20000, -1, 1, 25000};
		runCase(42);

		stepCycle();
		stepCycle();
		if (expQ.size() != 0)
		begin
			errorCount++;
			$display("Readback queue still holds %0d entries at the end", expQ.size());
		end
		$display("Cases: %0d, checks: %0d, errors: %0d", caseCount, checkCount, errorCount);
		if (errorCount == 0)
		begin
			$display("TESTS PASSED");
		end
		else
		begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

/* build.f */
+incdir+.
lspPkg.sv
basicOps.sv
scratchMemory.sv
lspStabilityFsm.sv
lspStabilityPipe.sv
tb_lspStability.sv

/* Bender.yml */
package:
  name: lsp_stability

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - lspPkg.sv
      - basicOps.sv
      - scratchMemory.sv
      - lspStabilityFsm.sv
      - lspStabilityPipe.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_lspStability.sv
